/* bitcount_pkg.sv */
// Bit counter shared definitions
package bitcount_pkg;

    localparam int bus_w   = 32; // Wishbone data and address width.
    localparam int count_w = 6;  // holds 0 to 32.

    // code 3 is not named and behaves as cpop.
    typedef enum logic [1:0] {
        op_clz  = 2'd0,
        op_ctz  = 2'd1,
        op_cpop = 2'd2
    } op_e;

    localparam logic [bus_w-1:0] reg_operand = 32'h0000_0000;
    localparam logic [bus_w-1:0] reg_control = 32'h0000_0004;
    localparam logic [bus_w-1:0] reg_result  = 32'h0000_0008; // read only.

    localparam int result_zero_bit = 8; // all-zero flag inside reg_result.

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [bus_w-1:0] adr;
        logic [bus_w-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic             err;
        logic [bus_w-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic             valid;
        op_e              op;
        logic [bus_w-1:0] operand;
    } count_req_t;

    typedef struct packed {
        logic               valid;
        logic [count_w-1:0] count;
        logic               all_zero;
    } count_rsp_t;

endpackage

/* zero_counter.sv */
// Trailing zero counter
`timescale 1ns/1ps

module zero_counter #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         value,
    output logic [$clog2(WIDTH):0]   zero_count,
    output logic                     all_zero
);

    localparam int CW = $clog2(WIDTH) + 1;

    // A zero word reports the full width, which needs the extra count bit.
    assign all_zero = ~(|value);

    // The loop walks downward so the last hit is the lowest set bit.
    always_comb begin
        zero_count = CW'(WIDTH);
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (value[i]) begin
                zero_count = CW'(i);
            end
        end
    end

endmodule

/* pop_counter.sv */
// Population counter
`timescale 1ns/1ps

module pop_counter #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]       value,
    output logic [$clog2(WIDTH):0] ones
);

    localparam int LEVELS = $clog2(WIDTH);

    genvar l;
    genvar n;

    // Level l holds WIDTH >> l partial sums, each l+1 bits wide.
    // A register stage can later be dropped between two levels.
    for (l = 0; l <= LEVELS; l++) begin : g_level
        logic [l:0] node [WIDTH >> l];

        for (n = 0; n < (WIDTH >> l); n++) begin : g_node
            if (l == 0) begin : g_leaf
                assign node[n] = value[n];
            end else begin : g_sum
                assign node[n] = {1'b0, g_level[l-1].node[2*n]}
                               + {1'b0, g_level[l-1].node[2*n+1]};
            end
        end
    end

    assign ones = g_level[LEVELS].node[0]; // root of the tree.

endmodule

/* bitcount_unit.sv */
// Two stage bit count pipeline
`timescale 1ns/1ps

module bitcount_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bitcount_pkg::count_req_t req,
    output bitcount_pkg::count_rsp_t rsp
);

    typedef struct packed {
        bitcount_pkg::op_e                    op;
        logic [bitcount_pkg::count_w-1:0]     zeros;
        logic [bitcount_pkg::count_w-1:0]     ones;
        logic                                 all_zero;
    } stage1_t;

    logic [bitcount_pkg::bus_w-1:0]   scan_word;
    logic [bitcount_pkg::count_w-1:0] zeros;
    logic [bitcount_pkg::count_w-1:0] ones;
    logic                             all_zero;

    logic                             s1_valid_q;
    stage1_t                          s1_q;
    logic                             rsp_valid_q;
    logic [bitcount_pkg::count_w-1:0] rsp_count_q;
    logic                             rsp_zero_q;

    // Leading zeros are the trailing zeros of the reversed word.
    always_comb begin
        if (req.op == bitcount_pkg::op_clz) begin
            scan_word = {<<{req.operand}};
        end else begin
            scan_word = req.operand;
        end
    end

    zero_counter #(
        .WIDTH (bitcount_pkg::bus_w)
    ) u_zero_counter (
        .value      (scan_word),
        .zero_count (zeros),
        .all_zero   (all_zero)
    );

    pop_counter #(
        .WIDTH (bitcount_pkg::bus_w)
    ) u_pop_counter (
        .value (req.operand),
        .ones  (ones)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            s1_valid_q  <= req.valid;
            rsp_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            s1_q <= '{op: req.op, zeros: zeros, ones: ones, all_zero: all_zero};
        end
        if (s1_valid_q) begin
            case (s1_q.op)
                bitcount_pkg::op_clz,
                bitcount_pkg::op_ctz: rsp_count_q <= s1_q.zeros;
                default:              rsp_count_q <= s1_q.ones; // code 3 counts ones too.
            endcase
            rsp_zero_q <= s1_q.all_zero;
        end
    end

    assign rsp = '{valid: rsp_valid_q, count: rsp_count_q, all_zero: rsp_zero_q};

endmodule

/* wb_bitcount_slave.sv */
// Wishbone bit count slave
`timescale 1ns/1ps

module wb_bitcount_slave #(
    parameter logic [bitcount_pkg::bus_w-1:0] BASE_ADDR = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bitcount_pkg::wb_req_t    wb_req,
    output bitcount_pkg::wb_rsp_t    wb_rsp,
    output bitcount_pkg::count_req_t count_req,
    input  bitcount_pkg::count_rsp_t count_rsp
);

    logic [bitcount_pkg::bus_w-1:0]   offset;
    logic                             sel_operand;
    logic                             sel_control;
    logic                             sel_result;
    logic                             legal;
    logic                             new_req;
    logic                             hold;
    logic                             do_ack;
    logic                             do_err;
    logic [bitcount_pkg::bus_w-1:0]   rd_data;

    logic                             ack_q;
    logic                             err_q;
    logic [bitcount_pkg::bus_w-1:0]   dat_r_q;
    logic                             issue_q;
    logic [1:0]                       inflight_q;
    logic [bitcount_pkg::bus_w-1:0]   operand_q;
    logic [1:0]                       control_q;
    logic [bitcount_pkg::count_w-1:0] result_count_q;
    logic                             result_zero_q;

    always_comb begin
        offset      = wb_req.adr - BASE_ADDR;
        sel_operand = (offset == bitcount_pkg::reg_operand);
        sel_control = (offset == bitcount_pkg::reg_control);
        sel_result  = (offset == bitcount_pkg::reg_result);
        legal       = sel_operand || sel_control || (sel_result && !wb_req.we);

        // A new transfer is one not yet answered in the previous cycle.
        new_req = wb_req.cyc && wb_req.stb && !ack_q && !err_q;
        hold    = new_req && sel_result && !wb_req.we && (inflight_q != 2'd0);
        do_ack  = new_req && legal && !hold;
        do_err  = new_req && !legal;
    end

    always_comb begin
        rd_data = '0;
        if (sel_operand) begin
            rd_data = operand_q;
        end else if (sel_control) begin
            rd_data[1:0] = control_q;
        end else begin
            rd_data[bitcount_pkg::count_w-1:0]      = result_count_q;
            rd_data[bitcount_pkg::result_zero_bit]  = result_zero_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q          <= 1'b0;
            err_q          <= 1'b0;
            issue_q        <= 1'b0;
            inflight_q     <= 2'd0;
            operand_q      <= '0;
            control_q      <= 2'd0;
            result_count_q <= '0;
            result_zero_q  <= 1'b0;
        end else begin
            ack_q   <= do_ack;
            err_q   <= do_err;
            issue_q <= do_ack && wb_req.we && sel_operand; // pulses alongside the ack.

            if (do_ack && wb_req.we && sel_operand) begin
                operand_q <= wb_req.dat_w;
            end
            if (do_ack && wb_req.we && sel_control) begin
                control_q <= wb_req.dat_w[1:0];
            end

            case ({issue_q, count_rsp.valid})
                2'b10:   inflight_q <= inflight_q + 2'd1;
                2'b01:   inflight_q <= inflight_q - 2'd1;
                default: inflight_q <= inflight_q;
            endcase

            if (count_rsp.valid) begin
                result_count_q <= count_rsp.count;
                result_zero_q  <= count_rsp.all_zero;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_ack && !wb_req.we) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp = '{ack: ack_q, err: err_q, dat_r: dat_r_q};

    // operand_q already holds the new word in the cycle of the pulse.
    assign count_req = '{
        valid:   issue_q,
        op:      bitcount_pkg::op_e'(control_q),
        operand: operand_q
    };

endmodule

/* bitcount_top.sv */
// Bit count coprocessor top
`timescale 1ns/1ps

module bitcount_top #(
    parameter logic [bitcount_pkg::bus_w-1:0] BASE_ADDR = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bitcount_pkg::wb_req_t wb_req,
    output bitcount_pkg::wb_rsp_t wb_rsp
);

    bitcount_pkg::count_req_t count_req; // issue pulse from the slave.
    bitcount_pkg::count_rsp_t count_rsp; // result two cycles later.

    wb_bitcount_slave #(
        .BASE_ADDR (BASE_ADDR)
    ) u_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .count_req (count_req),
        .count_rsp (count_rsp)
    );

    bitcount_unit u_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (count_req),
        .rsp   (count_rsp)
    );

endmodule

/* bitcount_asserts.sv */
// Bit count bus and result checks
`timescale 1ns/1ps

module bitcount_asserts #(
    parameter logic [bitcount_pkg::bus_w-1:0] BASE_ADDR = '0
) (
    input logic                  clk,
    input logic                  rst_n,
    input bitcount_pkg::wb_req_t wb_req,
    input bitcount_pkg::wb_rsp_t wb_rsp
);

    int fail_count = 0; // assertion failures seen so far.

    logic [31:0] offset;
    logic        req_on;
    logic        req_on_q;
    logic        start;
    logic        done;
    logic        is_operand;
    logic        is_control;
    logic        is_result;
    logic        illegal;
    logic [1:0]  age_q;      // cycles since the transfer began.
    logic [31:0] operand_q;
    logic [1:0]  control_q;
    logic [31:0] expected_q; // result register image after the latest operand write.

    function automatic int leading_zeros(input logic [31:0] w);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    function automatic int trailing_zeros(input logic [31:0] w);
        int n;
        n = 0;
        while (n < 32 && w[n] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    function automatic int ones(input logic [31:0] w);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += int'(w[i]);
        end
        return n;
    endfunction

    // Count in bits 5:0 and the zero flag in bit 8.
    function automatic logic [31:0] result_word(input logic [1:0] op, input logic [31:0] w);
        int count;
        case (op)
            2'd0:    count = leading_zeros(w);
            2'd1:    count = trailing_zeros(w);
            default: count = ones(w); // code 3 counts ones as well.
        endcase
        return {23'd0, (w == 32'd0), 2'd0, count[5:0]};
    endfunction

    always_comb begin
        offset     = wb_req.adr - BASE_ADDR;
        req_on     = wb_req.cyc && wb_req.stb;
        start      = req_on && !req_on_q;
        done       = wb_rsp.ack || wb_rsp.err;
        is_operand = (offset == bitcount_pkg::reg_operand);
        is_control = (offset == bitcount_pkg::reg_control);
        is_result  = (offset == bitcount_pkg::reg_result);
        illegal    = !(is_operand || is_control || is_result) || (is_result && wb_req.we);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_on_q   <= 1'b0;
            age_q      <= 2'd0;
            operand_q  <= '0;
            control_q  <= 2'd0;
            expected_q <= '0;
        end else begin
            req_on_q <= req_on;
            if (!req_on || done) begin
                age_q <= 2'd0;
            end else if (age_q != 2'd3) begin
                age_q <= age_q + 2'd1;
            end
            if (wb_rsp.ack && wb_req.we && is_control) begin
                control_q <= wb_req.dat_w[1:0];
            end
            if (wb_rsp.ack && wb_req.we && is_operand) begin
                operand_q  <= wb_req.dat_w;
                expected_q <= result_word(control_q, wb_req.dat_w); // op in force at issue.
            end
        end
    end

    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_rsp.ack && wb_rsp.err))
        else begin
            $error("ack and err were both high at %0t", $time);
            fail_count++;
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack stayed high for more than one cycle at %0t", $time);
            fail_count++;
        end

    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.err |=> !wb_rsp.err)
        else begin
            $error("err stayed high for more than one cycle at %0t", $time);
            fail_count++;
        end

    a_rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (req_on && age_q != 2'd0))
        else begin
            $error("a response came without a pending request at %0t", $time);
            fail_count++;
        end

    a_reg_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (start && (is_operand || is_control)) |=> (wb_rsp.ack && !wb_rsp.err))
        else begin
            $error("operand or control access was not acked after one cycle at %0t", $time);
            fail_count++;
        end

    a_bad_err: assert property (@(posedge clk) disable iff (!rst_n)
        (start && illegal) |=> (wb_rsp.err && !wb_rsp.ack))
        else begin
            $error("an illegal access did not get err after one cycle at %0t", $time);
            fail_count++;
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (req_on && age_q == 2'd3) |-> done)
        else begin
            $error("a transfer waited more than three cycles at %0t", $time);
            fail_count++;
        end

    a_operand_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_rsp.ack && !wb_req.we && is_operand) |-> (wb_rsp.dat_r == operand_q))
        else begin
            $error("FAILED %0t operand read gave %h, expected %h",
                   $time, wb_rsp.dat_r, operand_q);
            fail_count++;
        end

    a_control_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_rsp.ack && !wb_req.we && is_control) |-> (wb_rsp.dat_r == {30'd0, control_q}))
        else begin
            $error("FAILED %0t control read gave %h, expected %h",
                   $time, wb_rsp.dat_r, {30'd0, control_q});
            fail_count++;
        end

    a_result_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_rsp.ack && !wb_req.we && is_result) |-> (wb_rsp.dat_r == expected_q))
        else begin
            $error("FAILED %0t result read gave %h, expected %h",
                   $time, wb_rsp.dat_r, expected_q);
            fail_count++;
        end

endmodule

/* tb_bitcount.sv */
// Bit count coprocessor testbench
`timescale 1ns/1ps

module tb_bitcount;

    localparam logic [31:0] base_addr   = 32'h4000_0100;
    localparam int          clk_period  = 40;
    localparam int          n_random    = 200;
    localparam int          n_transfers = 3 * n_random + 100; // random items plus directed ones.
    localparam int          time_limit  = n_transfers * 5 * clk_period + 200 * clk_period;

    logic                  clk;
    logic                  rst_n;
    bitcount_pkg::wb_req_t wb_req;
    bitcount_pkg::wb_rsp_t wb_rsp;
    logic [31:0]           rand_state;
    int                    timeouts;

    bitcount_top #(
        .BASE_ADDR (base_addr)
    ) uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind bitcount_top bitcount_asserts #(
        .BASE_ADDR (BASE_ADDR)
    ) u_asserts (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // One classic transfer; stb drops for a cycle after the response.
    task automatic bus_transfer(input logic write, input logic [31:0] offset,
                                input logic [31:0] data);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: base_addr + offset, dat_w: data};
        do begin
            @(negedge clk);
        end while (!(wb_rsp.ack || wb_rsp.err));
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic write_reg(input logic [31:0] offset, input logic [31:0] data);
        bus_transfer(1'b1, offset, data);
    endtask

    task automatic read_reg(input logic [31:0] offset);
        bus_transfer(1'b0, offset, 32'd0);
    endtask

    // Upper control bits carry noise so the read-back mask is exercised.
    task automatic count_item(input logic [1:0] op, input logic [31:0] operand,
                              input logic [31:0] noise);
        write_reg(bitcount_pkg::reg_control, {noise[31:2], op});
        write_reg(bitcount_pkg::reg_operand, operand);
        read_reg(bitcount_pkg::reg_result);
    endtask

    task automatic finish_run();
        int failures;
        failures = uut.u_asserts.fail_count;
        $display("errors: %0d assertion failures, %0d timeouts", failures, timeouts);
        if (failures == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        #(time_limit);
        timeouts++;
        $display("timeout: the run did not finish within %0d ns", time_limit);
        finish_run();
    end

    initial begin
        logic [31:0] word;
        logic [31:0] noise;
        rst_n      = 1'b0;
        wb_req     = '0;
        rand_state = 32'h8436_bc37;
        timeouts   = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(bitcount_pkg::reg_operand); // reset values come first.
        read_reg(bitcount_pkg::reg_control);
        read_reg(bitcount_pkg::reg_result);

        for (int k = 0; k < 3; k++) begin
            count_item(2'(k), 32'h0000_0000, 32'd0);
            count_item(2'(k), 32'hffff_ffff, 32'd0);
            count_item(2'(k), 32'h0000_0001, 32'd0);
            count_item(2'(k), 32'h8000_0000, 32'd0);
            count_item(2'(k), 32'h0001_0000, 32'd0);
        end

        // Two operand writes with no read in between.
        write_reg(bitcount_pkg::reg_control, {30'd0, bitcount_pkg::op_ctz});
        write_reg(bitcount_pkg::reg_operand, 32'h0000_0100);
        write_reg(bitcount_pkg::reg_operand, 32'h0040_0000);
        read_reg(bitcount_pkg::reg_result);

        write_reg(bitcount_pkg::reg_control, 32'hffff_fffe);
        read_reg(bitcount_pkg::reg_control);
        write_reg(bitcount_pkg::reg_operand, 32'h1234_5678);
        read_reg(bitcount_pkg::reg_operand);
        read_reg(bitcount_pkg::reg_result);

        // Unmapped offsets and a write to the read-only result.
        read_reg(32'h0000_000c);
        write_reg(32'h0000_0100, 32'hdead_beef);
        read_reg(32'hffff_fffc); // one word below the base.
        write_reg(bitcount_pkg::reg_result, 32'h0000_003f);
        read_reg(bitcount_pkg::reg_result);

        for (int i = 0; i < n_random; i++) begin
            noise = next_rand();
            word  = next_rand();
            if (i % 3 == 0) begin
                word = word >> noise[4:0]; // leading zeros.
            end else if (i % 3 == 1) begin
                word = word << noise[9:5]; // trailing zeros.
            end
            count_item(2'(i % 4), word, noise);
            if (i % 16 == 0) begin
                read_reg(bitcount_pkg::reg_operand);
                read_reg(bitcount_pkg::reg_control);
            end
        end

        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

/* list.f */
bitcount_pkg.sv
zero_counter.sv
pop_counter.sv
bitcount_unit.sv
wb_bitcount_slave.sv
bitcount_top.sv
bitcount_asserts.sv
tb_bitcount.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bitcount
FILELIST = list.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100000 > $(LOG) 2>&1 || true
	@cat $(LOG)

check: run
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
